/* source/rv_pkg.sv */
package rv_pkg;

  localparam int xlen = 32;

  // RV32I major opcodes
  localparam logic [6:0] opc_lui     = 7'b01_101_11;
  localparam logic [6:0] opc_auipc   = 7'b00_101_11;
  localparam logic [6:0] opc_jal     = 7'b11_011_11;
  localparam logic [6:0] opc_jalr    = 7'b11_001_11;
  localparam logic [6:0] opc_branch  = 7'b11_000_11;
  localparam logic [6:0] opc_store   = 7'b01_000_11;
  localparam logic [6:0] opc_reg_imm = 7'b00_100_11;
  localparam logic [6:0] opc_reg_reg = 7'b01_100_11;
  localparam logic [6:0] opc_environ = 7'b11_100_11;

  // classification of each writeback cycle, one-hot above invalid
  typedef enum logic [31:0] {
    cycle_invalid      = 32'd0,
    cycle_reset        = 32'd1,
    cycle_no_stall     = 32'd2,
    cycle_taken_branch = 32'd4
  } cycle_status_e;

  // one instruction word, seen through each encoding format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } insn_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    insn_t           insn;
    cycle_status_e   cycle_status;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] imm;
  } decode_out_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    insn_t           insn;
    cycle_status_e   cycle_status;
    logic [xlen-1:0] result;
    logic            rd_we;
  } exec_out_t;

  typedef struct packed {
    logic            we;
    logic [4:0]      addr;
    logic [xlen-1:0] data;
  } rf_write_t;

  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;
  } redirect_t;

endpackage

/* source/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  rv_pkg::redirect_t         redirect,
  output logic [rv_pkg::xlen-1:0]   pc
);

  // sequential fetch unless execute resolved a taken transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (redirect.taken) begin
      pc <= redirect.target;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  // redirect targets from execute must keep fetch word-aligned
  pc_aligned_a: assert property (
    @(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00
  ) else $error("fetch pc %h is not word-aligned", pc);

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [4:0]              rs1_addr,
  input  logic [4:0]              rs2_addr,
  output logic [rv_pkg::xlen-1:0] rs1_data,
  output logic [rv_pkg::xlen-1:0] rs2_data,
  input  rv_pkg::rf_write_t       write
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [32];

  // x0 reads zero and a same-cycle write passes straight through
  function automatic logic [xlen-1:0] read_port(input logic [4:0] addr);
    logic [xlen-1:0] value;
    if (addr == 5'd0) begin
      value = '0;
    end else if (write.we && write.addr == addr) begin
      value = write.data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  assign rs1_data = read_port(rs1_addr);
  assign rs2_data = read_port(rs2_addr);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (write.we && write.addr != 5'd0) begin
      regs[write.addr] <= write.data;
    end
  end

  // execute drops the write enable for rd zero
  x0_no_write_a: assert property (
    @(posedge clk) disable iff (rst)
    write.we |-> write.addr != 5'd0
  ) else $error("enabled write to x0 presented to the register file");

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [rv_pkg::xlen-1:0] pc,
  input  logic [31:0]             insn,
  input  rv_pkg::redirect_t       redirect,
  input  rv_pkg::rf_write_t       wb_write,
  output rv_pkg::decode_out_t     decode_out
);
  import rv_pkg::*;

  logic [xlen-1:0] d_pc;
  insn_t           d_insn;
  cycle_status_e   d_status;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= cycle_reset;
    end else if (redirect.taken) begin
      // wrong-path fetch becomes a bubble
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= cycle_taken_branch;
    end else begin
      d_pc     <= pc;
      d_insn   <= insn;
      d_status <= cycle_no_stall;
    end
  end

  // sign-extended immediates per format
  assign imm_i = {{20{d_insn.i.imm_11_0[11]}}, d_insn.i.imm_11_0};
  assign imm_s = {{20{d_insn.s.imm_11_5[6]}}, d_insn.s.imm_11_5, d_insn.s.imm_4_0};
  assign imm_b = {{19{d_insn.b.imm_12}}, d_insn.b.imm_12, d_insn.b.imm_11,
                  d_insn.b.imm_10_5, d_insn.b.imm_4_1, 1'b0};
  assign imm_j = {{11{d_insn.j.imm_20}}, d_insn.j.imm_20, d_insn.j.imm_19_12,
                  d_insn.j.imm_11, d_insn.j.imm_10_1, 1'b0};
  // upper immediate already in place
  assign imm_u = {d_insn.u.imm_31_12, 12'd0};

  always_comb begin
    case (d_insn.r.opcode)
      opc_reg_imm, opc_jalr: imm = imm_i;
      // store format decoded, execute has no store path
      opc_store:             imm = imm_s;
      opc_branch:            imm = imm_b;
      opc_jal:               imm = imm_j;
      opc_lui, opc_auipc:    imm = imm_u;
      default:               imm = '0;
    endcase
  end

  reg_file reg_file_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (d_insn.r.rs1),
    .rs2_addr (d_insn.r.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .write    (wb_write)
  );

  assign decode_out = '{
    pc:           d_pc,
    insn:         d_insn,
    cycle_status: d_status,
    rs1_val:      rs1_data,
    rs2_val:      rs2_data,
    imm:          imm
  };

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
  input  logic                clk,
  input  logic                rst,
  input  rv_pkg::decode_out_t decode_out,
  input  rv_pkg::rf_write_t   mem_fwd,
  input  rv_pkg::rf_write_t   wb_fwd,
  output rv_pkg::exec_out_t   exec_out,
  output rv_pkg::redirect_t   redirect
);
  import rv_pkg::*;

  decode_out_t            ex_reg;
  insn_t                  insn;
  logic [xlen-1:0]        op_a;
  logic [xlen-1:0]        rs2_val;
  logic [xlen-1:0]        op_b;
  logic signed [xlen-1:0] sra_out;
  logic [xlen-1:0]        alu_out;
  logic [xlen-1:0]        result;
  logic                   alt;
  logic                   cond;
  logic                   writes_rd;

  // the newest producer wins and x0 is never forwarded
  function automatic logic [xlen-1:0] forward(input logic [4:0] src,
                                              input logic [xlen-1:0] decoded);
    logic [xlen-1:0] value;
    if (src != 5'd0 && mem_fwd.we && mem_fwd.addr == src) begin
      value = mem_fwd.data;
    end else if (src != 5'd0 && wb_fwd.we && wb_fwd.addr == src) begin
      value = wb_fwd.data;
    end else begin
      value = decoded;
    end
    return value;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_reg              <= '0;
      ex_reg.cycle_status <= cycle_reset;
    end else if (redirect.taken) begin
      // younger instruction from decode is squashed
      ex_reg              <= '0;
      ex_reg.cycle_status <= cycle_taken_branch;
    end else begin
      ex_reg <= decode_out;
    end
  end

  assign insn    = ex_reg.insn;
  assign op_a    = forward(insn.r.rs1, ex_reg.rs1_val);
  assign rs2_val = forward(insn.r.rs2, ex_reg.rs2_val);
  assign op_b    = (insn.r.opcode == opc_reg_reg) ? rs2_val : ex_reg.imm;
  // selects sub, sra and srai
  assign alt     = insn.r.funct7[5];
  assign sra_out = $signed(op_a) >>> op_b[4:0];

  always_comb begin
    case (insn.r.funct3)
      3'b000:  alu_out = (insn.r.opcode == opc_reg_reg && alt) ? op_a - op_b : op_a + op_b;
      3'b001:  alu_out = op_a << op_b[4:0];
      3'b010:  alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
      3'b011:  alu_out = {31'd0, op_a < op_b};
      3'b100:  alu_out = op_a ^ op_b;
      3'b101:  alu_out = alt ? sra_out : op_a >> op_b[4:0];
      3'b110:  alu_out = op_a | op_b;
      default: alu_out = op_a & op_b;
    endcase
  end

  always_comb begin
    writes_rd = 1'b1;
    case (insn.r.opcode)
      opc_lui:                  result = ex_reg.imm;
      opc_auipc:                result = ex_reg.pc + ex_reg.imm;
      opc_jal, opc_jalr:        result = ex_reg.pc + 32'd4;
      opc_reg_imm, opc_reg_reg: result = alu_out;
      default: begin
        result    = '0;
        writes_rd = 1'b0;
      end
    endcase
  end

  // branch conditions compare the forwarded operands
  always_comb begin
    case (insn.r.funct3)
      3'b000:  cond = op_a == rs2_val;
      3'b001:  cond = op_a != rs2_val;
      3'b100:  cond = $signed(op_a) < $signed(rs2_val);
      3'b101:  cond = $signed(op_a) >= $signed(rs2_val);
      3'b110:  cond = op_a < rs2_val;
      3'b111:  cond = op_a >= rs2_val;
      default: cond = 1'b0;
    endcase
  end

  assign redirect.taken  = (insn.r.opcode == opc_branch && cond) ||
                           insn.r.opcode == opc_jal || insn.r.opcode == opc_jalr;
  assign redirect.target = (insn.r.opcode == opc_jalr) ?
                           ((op_a + ex_reg.imm) & ~32'd1) : ex_reg.pc + ex_reg.imm;

  assign exec_out = '{
    pc:           ex_reg.pc,
    insn:         ex_reg.insn,
    cycle_status: ex_reg.cycle_status,
    result:       result,
    rd_we:        writes_rd && insn.r.rd != 5'd0
  };

endmodule

/* source/retire_stage.sv */
`timescale 1ns/1ns

module retire_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_pkg::exec_out_t       exec_out,
  output rv_pkg::rf_write_t       mem_fwd,
  output rv_pkg::rf_write_t       wb_write,
  output logic                    halt,
  output logic [rv_pkg::xlen-1:0] trace_pc,
  output logic [31:0]             trace_insn,
  output rv_pkg::cycle_status_e   trace_status
);
  import rv_pkg::*;

  exec_out_t mem_reg;
  exec_out_t wb_reg;

  // memory stage is a plain pass-through register
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_reg              <= '0;
      mem_reg.cycle_status <= cycle_reset;
      wb_reg               <= '0;
      wb_reg.cycle_status  <= cycle_reset;
    end else begin
      mem_reg <= exec_out;
      wb_reg  <= mem_reg;
    end
  end

  assign mem_fwd = '{we: mem_reg.rd_we, addr: mem_reg.insn.r.rd, data: mem_reg.result};

  // only the exact ecall word halts
  assign halt = wb_reg.insn.r.opcode == opc_environ && wb_reg.insn[31:7] == 25'd0;

  assign wb_write = '{we: wb_reg.rd_we && !halt, addr: wb_reg.insn.r.rd, data: wb_reg.result};

  assign trace_pc     = wb_reg.pc;
  assign trace_insn   = wb_reg.insn;
  assign trace_status = wb_reg.cycle_status;

  // an ecall leaves execute without a write enable
  halt_no_write_a: assert property (
    @(posedge clk) disable iff (rst)
    halt |-> !wb_reg.rd_we
  ) else $error("register write alongside halt");

endmodule

/* source/riscv_core.sv */
`timescale 1ns/1ns

module riscv_core #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = 32'h0000_0000
) (
  input  logic                    clk,
  input  logic                    rst,
  output logic [rv_pkg::xlen-1:0] pc_to_imem,
  input  logic [31:0]             insn_from_imem,
  output logic                    halt,
  output logic [rv_pkg::xlen-1:0] trace_writeback_pc,
  output logic [31:0]             trace_writeback_insn,
  output rv_pkg::cycle_status_e   trace_writeback_cycle_status,
  output rv_pkg::rf_write_t       trace_rf_write
);
  import rv_pkg::*;

  redirect_t   redirect;
  decode_out_t decode_out;
  exec_out_t   exec_out;
  rf_write_t   mem_fwd;
  rf_write_t   wb_write;

  fetch_unit #(
    .reset_pc (reset_pc)
  ) fetch_unit_inst (
    .clk      (clk),
    .rst      (rst),
    .redirect (redirect),
    .pc       (pc_to_imem)
  );

  decode_stage decode_stage_inst (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc_to_imem),
    .insn       (insn_from_imem),
    .redirect   (redirect),
    .wb_write   (wb_write),
    .decode_out (decode_out)
  );

  execute_stage execute_stage_inst (
    .clk        (clk),
    .rst        (rst),
    .decode_out (decode_out),
    .mem_fwd    (mem_fwd),
    .wb_fwd     (wb_write),
    .exec_out   (exec_out),
    .redirect   (redirect)
  );

  retire_stage retire_stage_inst (
    .clk          (clk),
    .rst          (rst),
    .exec_out     (exec_out),
    .mem_fwd      (mem_fwd),
    .wb_write     (wb_write),
    .halt         (halt),
    .trace_pc     (trace_writeback_pc),
    .trace_insn   (trace_writeback_insn),
    .trace_status (trace_writeback_cycle_status)
  );

  assign trace_rf_write = wb_write;

endmodule

/* verif/core_ref_model.svh */
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

// one expected writeback cycle
typedef struct packed {
  logic [31:0]   pc;
  logic [31:0]   insn;
  cycle_status_e status;
  logic          we;
  logic [4:0]    rd;
  logic [31:0]   data;
} retire_rec_t;

retire_rec_t expected_q [$];

// words past the end of the program read as ecall
function automatic logic [31:0] fetch_word(input logic [31:0] addr);
  logic [31:0] offset;
  logic [31:0] word;
  offset = addr - start_pc;
  if (addr >= start_pc && offset[31:2] < 30'(program_words.size())) begin
    word = program_words[offset[31:2]];
  end else begin
    word = ecall_word;
  end
  return word;
endfunction

function automatic logic [31:0] imm_i(input logic [31:0] w);
  return {{20{w[31]}}, w[31:20]};
endfunction

function automatic logic [31:0] imm_b(input logic [31:0] w);
  return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
endfunction

function automatic logic [31:0] imm_j(input logic [31:0] w);
  return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
endfunction

function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                           input logic is_reg, input logic [31:0] a,
                                           input logic [31:0] b);
  logic [31:0] r;
  case (f3)
    3'b000:  r = (is_reg && alt) ? a - b : a + b;
    3'b001:  r = a << b[4:0];
    3'b010:  r = {31'd0, $signed(a) < $signed(b)};
    3'b011:  r = {31'd0, a < b};
    3'b100:  r = a ^ b;
    3'b101:  r = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110:  r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
  logic t;
  case (f3)
    3'b000:  t = a == b;
    3'b001:  t = a != b;
    3'b100:  t = $signed(a) < $signed(b);
    3'b101:  t = $signed(a) >= $signed(b);
    3'b110:  t = a < b;
    3'b111:  t = a >= b;
    default: t = 1'b0;
  endcase
  return t;
endfunction

// runs the program at instruction level and queues every writeback cycle
function automatic void run_reference();
  logic [31:0] regs [32];
  logic [31:0] pc;
  logic [31:0] word;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;
  logic [31:0] next_pc;
  logic        writes;
  logic        taken;
  logic        we;
  for (int k = 0; k < 32; k++) begin
    regs[k] = '0;
  end
  expected_q.delete();
  for (int k = 0; k < 4; k++) begin
    expected_q.push_back('{pc: '0, insn: '0, status: cycle_reset, we: 1'b0, rd: '0, data: '0});
  end
  pc = start_pc;
  for (int steps = 0; steps < 5000; steps++) begin
    word    = fetch_word(pc);
    a       = regs[word[19:15]];
    b       = regs[word[24:20]];
    writes  = 1'b1;
    taken   = 1'b0;
    res     = '0;
    next_pc = pc + 32'd4;
    case (word[6:0])
      op_lui:   res = {word[31:12], 12'd0};
      op_auipc: res = pc + {word[31:12], 12'd0};
      op_jal: begin
        res     = pc + 32'd4;
        taken   = 1'b1;
        next_pc = pc + imm_j(word);
      end
      op_jalr: begin
        res     = pc + 32'd4;
        taken   = 1'b1;
        next_pc = (a + imm_i(word)) & ~32'd1;
      end
      op_branch: begin
        writes = 1'b0;
        taken  = branch_taken(word[14:12], a, b);
        if (taken) begin
          next_pc = pc + imm_b(word);
        end
      end
      op_imm:   res = alu_result(word[14:12], word[30], 1'b0, a, imm_i(word));
      op_reg:   res = alu_result(word[14:12], word[30], 1'b1, a, b);
      default:  writes = 1'b0;
    endcase
    we = writes && word[11:7] != 5'd0;
    expected_q.push_back('{pc: pc, insn: word, status: cycle_no_stall, we: we,
                           rd: word[11:7], data: res});
    if (we) begin
      regs[word[11:7]] = res;
    end
    if (word == ecall_word) begin
      break;
    end
    if (taken) begin
      for (int k = 0; k < 2; k++) begin
        expected_q.push_back('{pc: '0, insn: '0, status: cycle_taken_branch, we: 1'b0,
                               rd: '0, data: '0});
      end
    end
    pc = next_pc;
  end
endfunction

`endif

/* verif/core_tb.sv */
`timescale 1ns/1ns

module core_tb;
  import rv_pkg::*;

  localparam logic [31:0] start_pc   = 32'h0000_0100;
  localparam logic [31:0] ecall_word = 32'h0000_0073;
  localparam logic [6:0]  op_lui     = 7'h37;
  localparam logic [6:0]  op_auipc   = 7'h17;
  localparam logic [6:0]  op_jal     = 7'h6f;
  localparam logic [6:0]  op_jalr    = 7'h67;
  localparam logic [6:0]  op_branch  = 7'h63;
  localparam logic [6:0]  op_imm     = 7'h13;
  localparam logic [6:0]  op_reg     = 7'h33;

  logic [31:0] program_words [$];

  `include "core_ref_model.svh"

  logic          clk;
  logic          rst;
  logic [31:0]   pc_to_imem;
  logic [31:0]   insn_from_imem;
  logic          halt;
  logic [31:0]   trace_writeback_pc;
  logic [31:0]   trace_writeback_insn;
  cycle_status_e trace_writeback_cycle_status;
  rf_write_t     trace_rf_write;
  logic          checking;
  logic          done;
  int            error_count;
  int            cycle_count;
  int            watchdog_limit;

  riscv_core #(
    .reset_pc (start_pc)
  ) riscv_core_inst (
    .clk                          (clk),
    .rst                          (rst),
    .pc_to_imem                   (pc_to_imem),
    .insn_from_imem               (insn_from_imem),
    .halt                         (halt),
    .trace_writeback_pc           (trace_writeback_pc),
    .trace_writeback_insn         (trace_writeback_insn),
    .trace_writeback_cycle_status (trace_writeback_cycle_status),
    .trace_rf_write               (trace_rf_write)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // instruction memory answers within the cycle
  always @(negedge clk) begin
    insn_from_imem <= fetch_word(pc_to_imem);
  end

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] encode_b(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic logic [31:0] encode_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      error_count++;
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "trace mismatch");
    end
  endtask

  // compare the writeback trace against the reference queue
  always @(negedge clk) begin : compare_trace
    retire_rec_t exp;
    if (checking) begin
      exp = expected_q.pop_front();
      check_field("trace_writeback_pc", exp.pc, trace_writeback_pc);
      check_field("trace_writeback_insn", exp.insn, trace_writeback_insn);
      check_field("trace_writeback_cycle_status", 32'(exp.status),
                  32'(trace_writeback_cycle_status));
      check_field("trace_rf_write.we", 32'(exp.we), 32'(trace_rf_write.we));
      if (exp.we) begin
        check_field("trace_rf_write.addr", 32'(exp.rd), 32'(trace_rf_write.addr));
        check_field("trace_rf_write.data", exp.data, trace_rf_write.data);
      end
      check_field("halt", 32'(exp.insn == ecall_word), 32'(halt));
      // halt in writeback ends the program
      if (halt) begin
        checking <= 1'b0;
        done     <= 1'b1;
      end
    end
  end

  // limit grows with every program that is loaded
  initial begin
    forever begin
      @(negedge clk);
      cycle_count++;
      if (cycle_count > watchdog_limit) begin
        $display("timeout: the core did not reach ecall in time");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog");
      end
    end
  end

  task automatic run_program(input string label);
    watchdog_limit += 20 * program_words.size() + 60;
    run_reference();
    repeat (4) @(negedge clk);
    checking <= 1'b1;
    @(negedge clk);
    rst = 1'b0;
    wait (done);
    done = 1'b0;
    rst  = 1'b1;
    $display("program %s reached ecall", label);
  endtask

  task automatic build_alu_program();
    program_words.delete();
    program_words.push_back({20'h80000, 5'd1, op_lui});
    program_words.push_back(encode_i(12'hffb, 5'd0, 3'b000, 5'd2, op_imm));
    program_words.push_back(encode_i(12'd7, 5'd2, 3'b000, 5'd3, op_imm));
    program_words.push_back(encode_r(7'h00, 5'd3, 5'd3, 3'b000, 5'd4));
    program_words.push_back(encode_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd5));
    program_words.push_back(encode_r(7'h00, 5'd3, 5'd2, 3'b010, 5'd6));
    program_words.push_back(encode_r(7'h00, 5'd3, 5'd2, 3'b011, 5'd7));
    program_words.push_back(encode_r(7'h20, 5'd3, 5'd1, 3'b101, 5'd8));
    program_words.push_back(encode_r(7'h00, 5'd3, 5'd1, 3'b101, 5'd9));
    program_words.push_back(encode_r(7'h00, 5'd3, 5'd2, 3'b001, 5'd10));
    program_words.push_back(encode_i(12'h401, 5'd2, 3'b101, 5'd11, op_imm));
    program_words.push_back(encode_i(12'd28, 5'd2, 3'b101, 5'd12, op_imm));
    program_words.push_back(encode_i(12'd31, 5'd3, 3'b001, 5'd13, op_imm));
    program_words.push_back(encode_i(12'hffc, 5'd2, 3'b010, 5'd14, op_imm));
    program_words.push_back(encode_i(12'hfff, 5'd2, 3'b011, 5'd15, op_imm));
    program_words.push_back(encode_i(12'h5a5, 5'd2, 3'b100, 5'd16, op_imm));
    program_words.push_back(encode_i(12'h0f0, 5'd16, 3'b110, 5'd17, op_imm));
    program_words.push_back(encode_i(12'h7ff, 5'd17, 3'b111, 5'd18, op_imm));
    program_words.push_back(encode_r(7'h00, 5'd17, 5'd16, 3'b100, 5'd19));
    program_words.push_back(encode_r(7'h00, 5'd18, 5'd19, 3'b110, 5'd20));
    program_words.push_back(encode_r(7'h00, 5'd20, 5'd16, 3'b111, 5'd21));
    // x0 stays zero when written
    program_words.push_back(encode_i(12'd5, 5'd1, 3'b000, 5'd0, op_imm));
    program_words.push_back(encode_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd22));
    program_words.push_back({20'h12345, 5'd23, op_auipc});
    program_words.push_back(encode_i(12'd1, 5'd23, 3'b000, 5'd24, op_imm));
    program_words.push_back(encode_i(12'd2, 5'd23, 3'b000, 5'd25, op_imm));
    program_words.push_back(encode_i(12'd3, 5'd23, 3'b000, 5'd26, op_imm));
  endtask

  task automatic build_branch_program();
    logic [31:0] skipped;
    skipped = encode_i(12'd99, 5'd0, 3'b000, 5'd31, op_imm);
    program_words.delete();
    program_words.push_back(encode_i(12'd5, 5'd0, 3'b000, 5'd1, op_imm));
    program_words.push_back(encode_i(12'd5, 5'd0, 3'b000, 5'd2, op_imm));
    program_words.push_back(encode_b(13'd8, 5'd2, 5'd1, 3'b000));
    program_words.push_back(skipped);
    program_words.push_back(encode_b(13'd8, 5'd2, 5'd1, 3'b001));
    program_words.push_back(encode_i(12'd2, 5'd0, 3'b000, 5'd4, op_imm));
    program_words.push_back(encode_i(12'hfff, 5'd0, 3'b000, 5'd5, op_imm));
    program_words.push_back(encode_b(13'd8, 5'd1, 5'd5, 3'b100));
    program_words.push_back(skipped);
    program_words.push_back(encode_b(13'd8, 5'd1, 5'd5, 3'b110));
    program_words.push_back(encode_b(13'd8, 5'd5, 5'd1, 3'b101));
    program_words.push_back(skipped);
    program_words.push_back(encode_b(13'd8, 5'd1, 5'd5, 3'b111));
    program_words.push_back(skipped);
    program_words.push_back(encode_j(21'd8, 5'd7));
    program_words.push_back(skipped);
    program_words.push_back({20'h00000, 5'd8, op_auipc});
    // odd offset whose target drops bit 0
    program_words.push_back(encode_i(12'd13, 5'd8, 3'b000, 5'd9, op_jalr));
    program_words.push_back(skipped);
    program_words.push_back(encode_i(12'd0, 5'd9, 3'b000, 5'd10, op_imm));
    program_words.push_back(encode_i(12'd3, 5'd0, 3'b000, 5'd11, op_imm));
    program_words.push_back(encode_i(12'hfff, 5'd11, 3'b000, 5'd11, op_imm));
    program_words.push_back(encode_b(13'h1ffc, 5'd0, 5'd11, 3'b001));
  endtask

  function automatic logic [31:0] random_insn();
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [6:0]  f7;
    logic [31:0] word;
    int          kind;
    kind = int'($urandom_range(0, 9));
    rd   = 5'($urandom_range(0, 7));
    rs1  = 5'($urandom_range(0, 7));
    rs2  = 5'($urandom_range(0, 7));
    f3   = 3'($urandom);
    imm  = 12'($urandom);
    if (kind < 4) begin
      if (f3 == 3'b001) begin
        imm = {7'd0, imm[4:0]};
      end else if (f3 == 3'b101) begin
        imm = {1'b0, imm[10], 5'd0, imm[4:0]};
      end
      word = encode_i(imm, rs1, f3, rd, op_imm);
    end else if (kind < 7) begin
      f7   = ((f3 == 3'b000 || f3 == 3'b101) && imm[0]) ? 7'h20 : 7'h00;
      word = encode_r(f7, rs2, rs1, f3, rd);
    end else if (kind == 7) begin
      word = {20'($urandom), rd, imm[0] ? op_lui : op_auipc};
    end else begin
      // funct3 2 and 3 are not branches
      if (f3 == 3'b010 || f3 == 3'b011) begin
        f3 = 3'b000;
      end
      word = encode_b(13'(4 * $urandom_range(2, 5)), rs2, rs1, f3);
    end
    return word;
  endfunction

  initial begin
    rst            = 1'b1;
    insn_from_imem = '0;
    checking       = 1'b0;
    done           = 1'b0;
    error_count    = 0;
    cycle_count    = 0;
    watchdog_limit = 0;
    void'($urandom(32'h9b36));
    build_alu_program();
    run_program("alu");
    build_branch_program();
    run_program("branch");
    program_words.delete();
    for (int k = 0; k < 200; k++) begin
      program_words.push_back(random_insn());
    end
    run_program("random");
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+verif
source/rv_pkg.sv
source/fetch_unit.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/retire_stage.sv
source/riscv_core.sv
verif/core_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = core_tb
FILELIST  = sources.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
